// File: testbench/pov_fb_stim.txt
# W addr data : APB write, R addr data pslverr : APB read with expected values
# S : one position sync, a full slice when streaming is enabled
R 004 00000000 0
R 008 00000000 1
R 000 00000000 0
W 100 00007FFF
W 104 0000001F
W 108 000003E0
W 10C 00007C00
W 110 00005555
W 114 00002AAA
W 118 00001234
W 11C 00004321
W 120 00000F0F
W 124 000070F0
W 128 00008001
W 12C 00003C3C
W 130 00006B5A
W 134 000014A5
W 138 00007BDE
W 13C 00000000
W 140 0000FFFF
W 144 00000421
W 148 00002108
W 14C 00004210
W 150 000056B5
W 154 0000294A
W 158 00007A3C
W 15C 000005C3
W 160 0000318C
W 164 00004E73
W 168 00001F00
W 16C 000060FF
W 170 00000C63
W 174 0000739C
W 178 00002D2D
W 17C 00005AD6
W 000 00000001
R 000 00000001 0
S
S
S
R 004 00000003 0
W 000 00000000
R 000 00000000 0
S
R 004 00000003 0

// File: tb.f
+incdir+verilog
verilog/pov_fb_pkg.sv
verilog/apb_slice_port.sv
verilog/slice_framebuffer.sv
verilog/driver_serializer.sv
verilog/pov_fb_top.sv
testbench/tb_clkgen.sv
testbench/pov_fb_checker.sv
testbench/tb_pov_fb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -Wno-fatal
TOP := tb_pov_fb
FILELIST := tb.f
OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log
PASS_MSG := Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_pov_fb.sv
`timescale 1ns/1ns
`include "pov_fb_cfg.svh"
`default_nettype none

module tb_pov_fb;

    localparam int PLANES_PER_SLICE = `FB_PLANES * `FB_MUX;
    localparam int WORD_BITS = 3 * `FB_LEDS;
    localparam int DISTINCT_DRV = `FB_DRIVERS / 2;
    // Planes below this index carry no colour bits
    localparam int FIRST_COLOUR_PLANE = `FB_PLANES - 5;
    localparam int RAM_WORDS = `FB_SLICES * `FB_IMAGE_WORDS;
    localparam int IDLE_WATCH = 40;
    // Three slices of 16 cycles per plane plus slack, the idle watches and setup
    localparam int CYCLE_LIMIT = 3 * (PLANES_PER_SLICE * 16 + 20) + IDLE_WATCH * 4 + 200;
    localparam int DRIVE_DELAY = 2;

    logic clk;
    logic nrst;
    logic psel;
    logic penable;
    logic pwrite;
    pov_fb_pkg::apb_addr_t paddr;
    pov_fb_pkg::apb_data_t pwdata;
    pov_fb_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;
    logic position_sync;
    logic driver_ready;
    logic [`FB_DRIVERS-1:0] drv_sdata;
    logic drv_sbit_valid;
    logic drv_latch;

    // Reference copy of the host view of the design
    pov_fb_pkg::pixel_t model_ram [RAM_WORDS];
    logic model_enable;
    int model_slice;
    int slices_run;
    int n_checks;
    int n_errors;
    int cycles = 0;
    logic [31:0] lcg_state;

    tb_clkgen #(.PERIOD_NS(40)) clkgen_i (.clk(clk));

    pov_fb_top dut_i (
        .clk(clk),
        .nrst(nrst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .position_sync(position_sync),
        .driver_ready(driver_ready),
        .drv_sdata(drv_sdata),
        .drv_sbit_valid(drv_sbit_valid),
        .drv_latch(drv_latch)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Pixel of LED l, distinct driver d and column m sits at l*4 + d*2 + m in a slice
    function automatic pov_fb_pkg::plane_word_t expected_plane(input int slice, input int col,
                                                               input int plane, input int drv);
        pov_fb_pkg::plane_word_t word;
        pov_fb_pkg::pixel_t pix;
        int b;
        int idx;
        word = '0;
        if (plane >= FIRST_COLOUR_PLANE) begin
            b = plane - FIRST_COLOUR_PLANE;
            for (int l = 0; l < `FB_LEDS; l++) begin
                idx = slice * `FB_IMAGE_WORDS + l * DISTINCT_DRV * `FB_MUX
                      + (drv / 2) * `FB_MUX + col;
                pix = model_ram[idx];
                word[3 * l] = pix[b];
                word[3 * l + 1] = pix[5 + b];
                word[3 * l + 2] = pix[10 + b];
            end
        end
        return word;
    endfunction

    task automatic check_plane(input string name, input pov_fb_pkg::plane_word_t got,
                               input pov_fb_pkg::plane_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%03h expected 0x%03h", name, got, exp);
        end else begin
            $display("ok  %s 0x%03h", name, got);
        end
    endtask

    task automatic check_apb(input string name, input pov_fb_pkg::apb_data_t got,
                             input pov_fb_pkg::apb_data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        end else begin
            $display("ok  %s 0x%08h", name, got);
        end
    endtask

    task automatic note_failure(input string msg);
        n_checks++;
        n_errors++;
        $display("FAIL %s", msg);
    endtask

    // Drives one setup and one access phase and returns just after a rising edge
    task automatic apb_transfer(input logic write, input pov_fb_pkg::apb_addr_t addr,
                                input pov_fb_pkg::apb_data_t wdata,
                                output pov_fb_pkg::apb_data_t rdata, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #DRIVE_DELAY;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // Collects every latched plane of one slice and compares it with the model
    task automatic run_slice(input bit random_ready);
        pov_fb_pkg::plane_word_t words [`FB_DRIVERS];
        int bits;
        int planes;
        int col;
        int plane;
        bits = 0;
        planes = 0;
        for (int j = 0; j < `FB_DRIVERS; j++) begin
            words[j] = '0;
        end
        position_sync = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        position_sync = 1'b0;
        while (planes < PLANES_PER_SLICE) begin
            @(negedge clk);
            if (drv_sbit_valid) begin
                // Bits arrive LSB first
                for (int j = 0; j < `FB_DRIVERS; j++) begin
                    if (bits < WORD_BITS) begin
                        words[j][bits] = drv_sdata[j];
                    end
                end
                bits++;
            end
            if (drv_latch) begin
                col = planes / `FB_PLANES;
                plane = `FB_PLANES - 1 - planes % `FB_PLANES;
                if (bits != WORD_BITS) begin
                    note_failure($sformatf("latch came after %0d valid bits instead of %0d",
                                           bits, WORD_BITS));
                end
                for (int j = 0; j < `FB_DRIVERS; j++) begin
                    check_plane($sformatf("drv_sdata[%0d] slice %0d col %0d plane %0d",
                                          j, model_slice, col, plane),
                                words[j], expected_plane(model_slice, col, plane, j));
                    words[j] = '0;
                end
                bits = 0;
                planes++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            if (random_ready) begin
                lcg_state = lcg_next(lcg_state);
                driver_ready = lcg_state[16];
            end
        end
        driver_ready = 1'b1;
        model_slice = (model_slice + 1) % `FB_SLICES;
        slices_run++;
    endtask

    // With streaming off a sync must leave the driver outputs quiet
    task automatic expect_idle_after_sync();
        int active;
        active = 0;
        position_sync = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        position_sync = 1'b0;
        repeat (IDLE_WATCH) begin
            @(negedge clk);
            if (drv_sbit_valid || drv_latch) begin
                active++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (active != 0) begin
            note_failure($sformatf("driver outputs active in %0d cycles with streaming off",
                                   active));
        end else begin
            n_checks++;
            $display("ok  no driver output after sync with streaming off");
        end
    endtask

    task automatic run_commands(input int fd);
        string line;
        byte op;
        int rc;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        pov_fb_pkg::apb_data_t rd;
        logic err;
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0) begin
                a = '0;
                d = '0;
                e = '0;
                rc = $sscanf(line, "%c %h %h %h", op, a, d, e);
                case (op)
                    "W": begin
                        apb_transfer(1'b1, a[11:0], d, rd, err);
                        if (a[11:0] == `FB_CTRL_ADDR) begin
                            model_enable = d[0];
                            // Turning streaming off restarts the slice sequence at slice 0
                            if (!d[0]) begin
                                model_slice = 0;
                            end
                        end else if (a[11:0] >= `FB_RAM_BASE && a[1:0] == 2'b00
                                     && a[11:0] < `FB_RAM_BASE + 4 * RAM_WORDS) begin
                            model_ram[(a[11:0] - `FB_RAM_BASE) >> 2] = d[15:0];
                        end
                    end
                    "R": begin
                        apb_transfer(1'b0, a[11:0], '0, rd, err);
                        check_apb($sformatf("prdata at 0x%03h", a[11:0]), rd, d);
                        check_apb($sformatf("pslverr at 0x%03h", a[11:0]),
                                  pov_fb_pkg::apb_data_t'(err), e);
                    end
                    "S": begin
                        if (model_enable) begin
                            run_slice(slices_run == 2);
                        end else begin
                            expect_idle_after_sync();
                        end
                    end
                    "#", " ", 8'h0a, 8'h0d: ;
                    default: note_failure($sformatf("unknown stimulus command in line: %s", line));
                endcase
            end
        end
    endtask

    // Ends a run that no longer makes progress
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped producing results", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int fd;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        position_sync = 1'b0;
        driver_ready = 1'b1;
        nrst = 1'b0;
        lcg_state = 32'h747719ae;
        model_enable = 1'b0;
        model_slice = 0;
        slices_run = 0;
        n_checks = 0;
        n_errors = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        nrst = 1'b1;
        @(negedge clk);
        if (drv_sbit_valid || drv_latch) begin
            note_failure("driver outputs active right after reset");
        end else begin
            n_checks++;
            $display("ok  driver outputs quiet after reset");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        fd = $fopen("testbench/pov_fb_stim.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open testbench/pov_fb_stim.txt");
        end else begin
            run_commands(fd);
            $fclose(fd);
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/pov_fb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pov_fb_checker (
    input logic clk,
    input logic nrst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic stream_enable,
    input logic drv_sbit_valid,
    input logic drv_latch
);

    // A latch closes a word, so it follows a data bit and never overlaps one
    latch_after_bits: assert property (@(posedge clk) disable iff (!nrst)
        drv_latch |-> !drv_sbit_valid && $past(drv_sbit_valid))
        else $error("drv_latch not directly preceded by drv_sbit_valid");

    // Error response only exists in the access phase
    slverr_in_access: assert property (@(posedge clk) disable iff (!nrst)
        pslverr |-> psel && penable)
        else $error("pslverr high outside an APB access phase");

    // With streaming off for two cycles nothing new reaches the idle serializer
    quiet_when_disabled: assert property (@(posedge clk) disable iff (!nrst)
        (!stream_enable && $past(!stream_enable) && !drv_sbit_valid && !drv_latch)
        |=> !drv_sbit_valid)
        else $error("drv_sbit_valid started while stream_enable is low");

    no_wait_states: assert property (@(posedge clk) disable iff (!nrst)
        pready)
        else $error("pready dropped low");

endmodule

bind pov_fb_top pov_fb_checker checker_i (
    .clk(clk),
    .nrst(nrst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .stream_enable(stream_enable),
    .drv_sbit_valid(drv_sbit_valid),
    .drv_latch(drv_latch)
);

`default_nettype wire

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // Free-running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verilog/pov_fb_top.sv
`timescale 1ns/1ns
`include "pov_fb_cfg.svh"
`default_nettype none

module pov_fb_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  pov_fb_pkg::apb_addr_t paddr,
    input  pov_fb_pkg::apb_data_t pwdata,
    output pov_fb_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  position_sync,
    input  logic                  driver_ready,
    output logic [`FB_DRIVERS-1:0] drv_sdata,
    output logic                  drv_sbit_valid,
    output logic                  drv_latch
);

    logic stream_enable;
    logic slice_done;
    pov_fb_pkg::ram_addr_t ram_addr;
    pov_fb_pkg::pixel_t ram_data;
    // Plane handshake between the framebuffer and the serializer
    logic plane_valid;
    logic plane_ready;
    pov_fb_pkg::plane_word_t [`FB_DRIVERS-1:0] plane_data;

    // Host registers and slice RAM
    apb_slice_port port_i (
        .clk(clk),
        .nrst(nrst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .stream_enable(stream_enable),
        .ram_addr(ram_addr),
        .ram_data(ram_data),
        .slice_done(slice_done)
    );

    slice_framebuffer fb_i (
        .clk(clk),
        .nrst(nrst),
        .stream_enable(stream_enable),
        .position_sync(position_sync),
        .ram_addr(ram_addr),
        .ram_data(ram_data),
        .plane_valid(plane_valid),
        .plane_data(plane_data),
        .plane_ready(plane_ready),
        .slice_done(slice_done)
    );

    // LED driver side
    driver_serializer ser_i (
        .clk(clk),
        .nrst(nrst),
        .driver_ready(driver_ready),
        .plane_valid(plane_valid),
        .plane_data(plane_data),
        .plane_ready(plane_ready),
        .drv_sdata(drv_sdata),
        .drv_sbit_valid(drv_sbit_valid),
        .drv_latch(drv_latch)
    );

endmodule

`default_nettype wire

// File: verilog/driver_serializer.sv
`timescale 1ns/1ns
`include "pov_fb_cfg.svh"
`default_nettype none

module driver_serializer (
    input  logic                                       clk,
    input  logic                                       nrst,
    input  logic                                       driver_ready,
    input  logic                                       plane_valid,
    input  pov_fb_pkg::plane_word_t [`FB_DRIVERS-1:0] plane_data,
    output logic                                       plane_ready,
    output logic [`FB_DRIVERS-1:0]                     drv_sdata,
    output logic                                       drv_sbit_valid,
    output logic                                       drv_latch
);

    // Three colour bits per LED
    localparam int WORD_BITS = 3 * `FB_LEDS;

    pov_fb_pkg::ser_state_t state;
    logic [3:0] bit_cnt;
    logic load;
    pov_fb_pkg::plane_word_t shreg [`FB_DRIVERS];

    // Back-pressure from the drivers only blocks the start of a new plane
    assign plane_ready = state == pov_fb_pkg::IDLE && driver_ready;
    assign load = plane_valid && plane_ready;
    assign drv_sbit_valid = state == pov_fb_pkg::SHIFT;
    assign drv_latch = state == pov_fb_pkg::LATCH;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= pov_fb_pkg::IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                pov_fb_pkg::IDLE: begin
                    bit_cnt <= '0;
                    if (load) begin
                        state <= pov_fb_pkg::SHIFT;
                    end
                end
                pov_fb_pkg::SHIFT: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    // Latch right after the last bit of the word
                    if (bit_cnt == 4'(WORD_BITS - 1)) begin
                        state <= pov_fb_pkg::LATCH;
                    end
                end
                default: state <= pov_fb_pkg::IDLE;
            endcase
        end
    end

    // LSB goes out first, all drivers shift in lock step
    always_ff @(posedge clk) begin
        for (int j = 0; j < `FB_DRIVERS; j++) begin
            if (load) begin
                shreg[j] <= plane_data[j];
            end else if (state == pov_fb_pkg::SHIFT) begin
                shreg[j] <= shreg[j] >> 1;
            end
        end
    end

    always_comb begin
        for (int j = 0; j < `FB_DRIVERS; j++) begin
            drv_sdata[j] = shreg[j][0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/slice_framebuffer.sv
`timescale 1ns/1ns
`include "pov_fb_cfg.svh"
`default_nettype none

module slice_framebuffer (
    input  logic                                       clk,
    input  logic                                       nrst,
    input  logic                                       stream_enable,
    input  logic                                       position_sync,
    output pov_fb_pkg::ram_addr_t                      ram_addr,
    input  pov_fb_pkg::pixel_t                         ram_data,
    output logic                                       plane_valid,
    output pov_fb_pkg::plane_word_t [`FB_DRIVERS-1:0] plane_data,
    input  logic                                       plane_ready,
    output logic                                       slice_done
);

    // One column holds a pixel per LED for every distinct driver
    localparam int HALF_DRV = `FB_DRIVERS / 2;
    localparam int COL_WORDS = `FB_LEDS * HALF_DRV;
    localparam int IDX_W = $clog2(COL_WORDS);
    localparam int SLICE_W = $clog2(`FB_SLICES);
    localparam int COL_W = $clog2(`FB_MUX);
    // Five bits per colour channel, the planes below them are sent as zeros
    localparam int CH_BITS = 5;
    localparam int ZERO_PLANES = `FB_PLANES - CH_BITS;

    pov_fb_pkg::fb_state_t state;
    logic [SLICE_W-1:0] slice_q;
    logic [COL_W-1:0] col_q;
    logic [3:0] plane_q;
    logic read_buf;
    logic [1:0] buf_full;
    logic fill_busy;
    logic [IDX_W-1:0] fill_cnt;
    logic [COL_W-1:0] fill_col;
    logic fill_buf;
    logic wr_pending;
    logic [IDX_W-1:0] wr_idx;
    logic wr_buf;
    logic fill_last;
    logic fill_start;
    logic [COL_W-1:0] fill_start_col;
    logic xfer;
    logic col_last;
    logic colour_plane;
    logic [2:0] bit_sel;
    pov_fb_pkg::pixel_t colbuf [2][COL_WORDS];

    assign xfer = plane_valid && plane_ready;
    assign col_last = col_q == COL_W'(`FB_MUX - 1);
    assign fill_last = wr_pending && wr_idx == IDX_W'(COL_WORDS - 1);
    // A column is only offered once its buffer has been completely written
    assign plane_valid = state == pov_fb_pkg::STREAM && buf_full[read_buf];

    // Entry k of a column sits FB_MUX words after entry k-1 in the slice
    assign ram_addr = pov_fb_pkg::ram_addr_t'(int'(slice_q) * `FB_IMAGE_WORDS
                      + int'(fill_col) + int'(fill_cnt) * `FB_MUX);

    // Sync starts column 0, the end of that fill queues column 1, and later
    // columns are queued into the buffer that has just been emptied
    always_comb begin
        fill_start = 1'b0;
        fill_start_col = '0;
        case (state)
            pov_fb_pkg::WAIT_SYNC: fill_start = position_sync;
            pov_fb_pkg::FILL: begin
                fill_start = fill_last && `FB_MUX > 1;
                fill_start_col = COL_W'(1);
            end
            pov_fb_pkg::STREAM: begin
                fill_start = xfer && plane_q == '0 && int'(col_q) + 2 < `FB_MUX;
                fill_start_col = COL_W'(int'(col_q) + 2);
            end
            default: ;
        endcase
    end

    // Fill engine issues one read per cycle, the write lags by the RAM latency
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fill_busy <= 1'b0;
            fill_cnt <= '0;
            fill_col <= '0;
            fill_buf <= 1'b0;
            wr_pending <= 1'b0;
            wr_idx <= '0;
            wr_buf <= 1'b0;
        end else if (!stream_enable) begin
            fill_busy <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= fill_busy;
            wr_idx <= fill_cnt;
            wr_buf <= fill_buf;
            if (fill_start) begin
                fill_busy <= 1'b1;
                fill_cnt <= '0;
                fill_col <= fill_start_col;
                // In FILL the first buffer is still unread, so the other one takes it
                fill_buf <= state == pov_fb_pkg::FILL ? ~read_buf : read_buf;
            end else if (fill_busy) begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == IDX_W'(COL_WORDS - 1)) begin
                    fill_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_pending) begin
            colbuf[wr_buf][wr_idx] <= ram_data;
        end
    end

    // Slice sequencing, planes go from the top one down to 0 for each column
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= pov_fb_pkg::WAIT_SYNC;
            slice_q <= '0;
            col_q <= '0;
            plane_q <= 4'(`FB_PLANES - 1);
            read_buf <= 1'b0;
            buf_full <= '0;
            slice_done <= 1'b0;
        end else if (!stream_enable) begin
            state <= pov_fb_pkg::WAIT_SYNC;
            slice_q <= '0;
            col_q <= '0;
            plane_q <= 4'(`FB_PLANES - 1);
            read_buf <= 1'b0;
            buf_full <= '0;
            slice_done <= 1'b0;
        end else begin
            slice_done <= 1'b0;
            if (fill_last) begin
                buf_full[wr_buf] <= 1'b1;
            end
            case (state)
                pov_fb_pkg::WAIT_SYNC: begin
                    if (position_sync) begin
                        state <= pov_fb_pkg::FILL;
                        col_q <= '0;
                        plane_q <= 4'(`FB_PLANES - 1);
                        read_buf <= 1'b0;
                    end
                end
                pov_fb_pkg::FILL: begin
                    if (fill_last) begin
                        state <= pov_fb_pkg::STREAM;
                    end
                end
                pov_fb_pkg::STREAM: begin
                    if (xfer && plane_q != '0) begin
                        plane_q <= plane_q - 4'd1;
                    end else if (xfer) begin
                        // Column finished, hand its buffer back to the fill engine
                        plane_q <= 4'(`FB_PLANES - 1);
                        buf_full[read_buf] <= 1'b0;
                        read_buf <= ~read_buf;
                        col_q <= col_last ? '0 : col_q + 1'b1;
                        if (col_last) begin
                            state <= pov_fb_pkg::WAIT_SYNC;
                            slice_done <= 1'b1;
                            slice_q <= slice_q == SLICE_W'(`FB_SLICES - 1) ? '0 : slice_q + 1'b1;
                        end
                    end
                end
                default: state <= pov_fb_pkg::WAIT_SYNC;
            endcase
        end
    end

    // Plane p above the zero planes carries bit p-4 of every colour channel
    assign colour_plane = int'(plane_q) >= ZERO_PLANES;
    assign bit_sel = 3'(int'(plane_q) - ZERO_PLANES);

    // Facing drivers j and j+1 read the same buffer entries
    always_comb begin
        pov_fb_pkg::pixel_t pix;
        for (int j = 0; j < `FB_DRIVERS; j++) begin
            plane_data[j] = '0;
            for (int l = 0; l < `FB_LEDS; l++) begin
                pix = colbuf[read_buf][l * HALF_DRV + j / 2];
                if (colour_plane) begin
                    plane_data[j][3 * l] = pix[bit_sel];
                    plane_data[j][3 * l + 1] = pix[CH_BITS + int'(bit_sel)];
                    plane_data[j][3 * l + 2] = pix[2 * CH_BITS + int'(bit_sel)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/apb_slice_port.sv
`timescale 1ns/1ns
`include "pov_fb_cfg.svh"
`default_nettype none

module apb_slice_port (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  pov_fb_pkg::apb_addr_t paddr,
    input  pov_fb_pkg::apb_data_t pwdata,
    output pov_fb_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  stream_enable,
    input  pov_fb_pkg::ram_addr_t ram_addr,
    output pov_fb_pkg::pixel_t    ram_data,
    input  logic                  slice_done
);

    localparam int RAM_WORDS = `FB_SLICES * `FB_IMAGE_WORDS;
    // Offset bits that select a word inside the RAM window
    localparam pov_fb_pkg::apb_addr_t RAM_MASK = pov_fb_pkg::apb_addr_t'((RAM_WORDS - 1) << 2);

    pov_fb_pkg::pixel_t ram [RAM_WORDS];
    pov_fb_pkg::ram_addr_t wr_index;
    logic [7:0] slices_done;
    logic access;
    logic ctrl_hit;
    logic status_hit;
    logic ram_hit;

    // Bus has no wait states, so every access phase completes at once
    assign pready = 1'b1;
    assign access = psel && penable;

    assign ctrl_hit = paddr == `FB_CTRL_ADDR;
    assign status_hit = paddr == `FB_STATUS_ADDR;
    // Only word-aligned offsets inside the pixel window hit the RAM
    assign ram_hit = (paddr & ~RAM_MASK) == `FB_RAM_BASE;
    assign wr_index = pov_fb_pkg::ram_addr_t'(paddr >> 2);

    // Unmapped offsets answer with an error in the access phase
    assign pslverr = access && !(ctrl_hit || status_hit || ram_hit);

    // Read data is combinational and valid during the access phase
    // The pixel window is write-only and reads back as zero
    always_comb begin
        prdata = '0;
        if (access && ctrl_hit) begin
            prdata[0] = stream_enable;
        end else if (access && status_hit) begin
            prdata[7:0] = slices_done;
        end
    end

    // Control register and the wrapping slice counter
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            stream_enable <= 1'b0;
            slices_done <= '0;
        end else begin
            if (access && pwrite && ctrl_hit) begin
                stream_enable <= pwdata[0];
            end
            if (slice_done) begin
                slices_done <= slices_done + 8'd1;
            end
        end
    end

    // Pixel memory with one host write port and one registered read port
    always_ff @(posedge clk) begin
        if (access && pwrite && ram_hit) begin
            ram[wr_index] <= pov_fb_pkg::pixel_t'(pwdata[15:0]);
        end
        ram_data <= ram[ram_addr];
    end

endmodule

`default_nettype wire

// File: verilog/pov_fb_pkg.sv
`default_nettype none

package pov_fb_pkg;

    // rgb555 pixel, red in 4:0, green in 9:5, blue in 14:10, bit 15 unused
    typedef logic [15:0] pixel_t;

    // Word index into the slice RAM
    typedef logic [4:0] ram_addr_t;

    // One driver's plane, three bits per LED in the order red, green, blue
    typedef logic [11:0] plane_word_t;

    // Host bus
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {WAIT_SYNC, FILL, STREAM} fb_state_t;
    typedef enum logic [1:0] {IDLE, SHIFT, LATCH} ser_state_t;

endpackage

`default_nettype wire

// File: verilog/pov_fb_cfg.svh
`ifndef POV_FB_CFG_SVH
`define POV_FB_CFG_SVH

// Panel geometry
// Drivers 2k and 2k+1 face each other and show the same column data
`define FB_DRIVERS 4
`define FB_LEDS 4
`define FB_MUX 2

// Poker mode sends nine planes, only the upper five carry colour bits
`define FB_PLANES 9

// Slice storage, one slice is FB_LEDS * FB_DRIVERS/2 * FB_MUX pixels
`define FB_SLICES 2
`define FB_IMAGE_WORDS 16

// APB byte offsets
`define FB_CTRL_ADDR 12'h000
`define FB_STATUS_ADDR 12'h004
`define FB_RAM_BASE 12'h100

`endif
